// ==== logic/fpu_pkg.sv ====
// shared types for the floating-point coprocessor
// operation codes, IEEE-754 field layout, request/response bundles and register map
// imported by every RTL block of the FPU
package fpu_pkg;

    // ============================
    // operation codes
    // ============================
    // unlisted codes produce a zero result and a clear compare bit
    typedef enum logic [3:0] {
        op_add = 4'd1,
        op_sub = 4'd2,
        op_mul = 4'd3,
        op_div = 4'd4,
        op_abs = 4'd5,
        op_eq  = 4'd6,
        op_neq = 4'd7,
        op_slt = 4'd8,
        op_f2i = 4'd9,
        op_i2f = 4'd10
    } fp_op_e;

    typedef logic [31:0] fp_word_t;

    // single-precision field split
    typedef struct packed {
        logic       sign;
        logic [7:0] exp;
        logic [22:0] frac;
    } fp_fields_t;

    localparam int unsigned exp_bias = 127;

    // ============================
    // datapath bundles
    // ============================
    typedef struct packed {
        fp_op_e   op;
        fp_word_t a;
        fp_word_t b;
    } fpu_req_t;

    typedef struct packed {
        fp_word_t result;
        logic     cmp;
    } fpu_rsp_t;

    // word index, taken from bus address bits 4:2
    // status layout is bit 0 busy, bit 1 cmp
    typedef enum logic [2:0] {
        reg_op1    = 3'd0,
        reg_op2    = 3'd1,
        reg_opcode = 3'd2,
        reg_result = 3'd3,
        reg_status = 3'd4
    } reg_addr_e;

endpackage

// ==== logic/floating_alu.sv ====
`timescale 1ns/1ns
// combinational single-precision ALU of the coprocessor
// add, sub, mul, abs, compares and int conversions settle within one cycle
// the divide code yields zero here since the sequential divider owns it
module floating_alu (
    input  fpu_pkg::fpu_req_t req,
    output fpu_pkg::fpu_rsp_t rsp
);
    import fpu_pkg::*;

    fp_fields_t  a_f;
    fp_fields_t  b_f;
    logic [23:0] a_sig;
    logic [23:0] b_sig;
    logic        b_sign;

    logic [7:0]  exp_diff;
    logic [24:0] mant_a;
    logic [24:0] mant_b;
    logic [24:0] sum;
    logic [7:0]  res_exp;
    logic        res_sign;
    logic [47:0] product;
    logic [23:0] mant;
    logic        up;
    logic [7:0]  unb_exp;
    logic [31:0] as_int;
    logic [31:0] abs_a;
    logic [4:0]  msb;

    // round by adding one at the lsb when asked to, renormalize on wrap
    function automatic fp_word_t pack_rounded(input logic sign, input logic [7:0] exp,
                                              input logic [23:0] m, input logic round_up);
        logic [23:0] rnd;
        logic [7:0]  e;
        fp_word_t    w;
        rnd = m + 24'd1;
        e = exp;
        if (!round_up) begin
            w = {sign, e, m[22:0]};
        end else if (rnd[23]) begin
            w = {sign, e, rnd[22:0]};
        end else begin
            e = e + 8'd1;
            w = {sign, e, rnd[23:1]};
        end
        return w;
    endfunction

    assign a_f = req.a;
    assign b_f = req.b;
    assign a_sig = {1'b1, a_f.frac};
    assign b_sig = {1'b1, b_f.frac};
    // subtract is an add with the second sign flipped
    assign b_sign = (req.op == op_sub) ? ~b_f.sign : b_f.sign;

    always_comb begin
        rsp.result = '0;
        rsp.cmp = 1'b0;
        exp_diff = '0;
        mant_a = '0;
        mant_b = '0;
        sum = '0;
        res_exp = '0;
        res_sign = 1'b0;
        product = '0;
        mant = '0;
        up = 1'b0;
        unb_exp = '0;
        as_int = '0;
        abs_a = '0;
        msb = '0;

        case (req.op)
            op_add, op_sub: begin
                // align the smaller operand to the larger exponent
                if (a_f.exp > b_f.exp) begin
                    exp_diff = a_f.exp - b_f.exp;
                    mant_a = {1'b0, a_sig};
                    mant_b = {1'b0, b_sig} >> exp_diff;
                    res_exp = a_f.exp;
                    res_sign = a_f.sign;
                end else begin
                    exp_diff = b_f.exp - a_f.exp;
                    mant_a = {1'b0, a_sig} >> exp_diff;
                    mant_b = {1'b0, b_sig};
                    res_exp = b_f.exp;
                    res_sign = b_sign;
                end

                // signed-magnitude add
                if (a_f.sign == b_sign) begin
                    sum = mant_a + mant_b;
                    if (sum[24]) begin
                        sum = sum >> 1;
                        res_exp = res_exp + 8'd1;
                    end
                end else if (mant_a >= mant_b) begin
                    sum = mant_a - mant_b;
                    res_sign = a_f.sign;
                end else begin
                    sum = mant_b - mant_a;
                    res_sign = b_sign;
                end

                if (sum != '0) begin
                    // left-normalize after cancellation
                    for (int i = 0; i < 24; i++) begin
                        if (!sum[23] && res_exp > 8'd0) begin
                            sum = sum << 1;
                            res_exp = res_exp - 8'd1;
                        end
                    end
                    up = sum[1] & (sum[0] | sum[2]);
                    rsp.result = pack_rounded(res_sign, res_exp, sum[23:0], up);
                end
            end

            op_mul: begin
                product = 48'(a_sig) * 48'(b_sig);
                res_sign = a_f.sign ^ b_f.sign;
                if (product[47]) begin
                    res_exp = a_f.exp + b_f.exp - 8'(exp_bias) + 8'd1;
                    mant = product[47:24];
                    up = product[23] & (product[22] | product[21]);
                end else begin
                    res_exp = a_f.exp + b_f.exp - 8'(exp_bias);
                    mant = product[46:23];
                    up = product[22] & (product[21] | product[20]);
                end
                rsp.result = pack_rounded(res_sign, res_exp, mant, up);
            end

            op_abs: rsp.result = {1'b0, req.a[30:0]};

            op_eq: rsp.cmp = (req.a == req.b);

            op_neq: rsp.cmp = (req.a != req.b);

            op_slt: begin
                if (a_f.sign != b_f.sign) begin
                    rsp.cmp = a_f.sign;
                end else if (a_f.exp != b_f.exp) begin
                    rsp.cmp = (a_f.exp < b_f.exp) ^ a_f.sign;
                end else begin
                    rsp.cmp = (a_sig < b_sig) ^ a_f.sign;
                end
            end

            op_f2i: begin
                unb_exp = a_f.exp - 8'(exp_bias);
                if (a_f.exp == 8'hff || (a_f.exp >= 8'(exp_bias) && unb_exp > 8'd30)) begin
                    // saturate toward the sign
                    rsp.result = a_f.sign ? 32'h8000_0000 : 32'h7fff_ffff;
                end else if (a_f.exp >= 8'(exp_bias)) begin
                    if (unb_exp >= 8'd23) begin
                        as_int = 32'(a_sig) << (unb_exp - 8'd23);
                    end else begin
                        as_int = 32'(a_sig) >> (8'd23 - unb_exp);
                    end
                    rsp.result = a_f.sign ? -as_int : as_int;
                end
            end

            op_i2f: begin
                if (req.a != '0) begin
                    abs_a = req.a[31] ? -req.a : req.a;
                    for (int i = 0; i < 32; i++) begin
                        if (abs_a[i]) begin
                            msb = 5'(i);
                        end
                    end
                    res_exp = 8'(exp_bias) + {3'b000, msb};
                    // bits below the 24-bit window are dropped
                    if (msb >= 5'd23) begin
                        mant = 24'(abs_a >> (msb - 5'd23));
                    end else begin
                        mant = 24'(abs_a << (5'd23 - msb));
                    end
                    rsp.result = {req.a[31], res_exp, mant[22:0]};
                end
            end

            // op_div and unknown codes leave the zero defaults
            default: ;
        endcase
    end

endmodule

// ==== logic/fp_divider.sv ====
`timescale 1ns/1ns
// sequential restoring divider for single-precision operands
// one quotient bit per cycle, 25 bits, then one normalization cycle with done high
module fp_divider (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  fpu_pkg::fpu_req_t req,
    output logic              done,
    output fpu_pkg::fpu_rsp_t rsp
);
    import fpu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_norm
    } div_state_e;

    div_state_e        state;
    logic [4:0]        bit_cnt;
    logic [24:0]       rem;
    logic [23:0]       den;
    logic [24:0]       quo;
    logic signed [9:0] exp_int;
    logic              res_sign;

    fp_fields_t        a_f;
    fp_fields_t        b_f;
    logic [24:0]       rem_in;
    logic [23:0]       den_in;
    logic              q_bit;
    logic [24:0]       rem_sub;

    logic signed [8:0] shift;
    logic signed [9:0] norm_exp;
    logic [7:0]        res_exp;
    logic [24:0]       quo_sh;
    logic              found;

    assign a_f = req.a;
    assign b_f = req.b;

    // the start cycle already resolves the first quotient bit from the request
    assign rem_in = start ? {2'b01, a_f.frac} : rem;
    assign den_in = start ? {1'b1, b_f.frac} : den;
    assign q_bit = (rem_in >= {1'b0, den_in});
    assign rem_sub = q_bit ? rem_in - {1'b0, den_in} : rem_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            bit_cnt <= '0;
        end else if (start) begin
            state <= st_run;
            bit_cnt <= 5'd1;
        end else begin
            case (state)
                st_run: begin
                    bit_cnt <= bit_cnt + 5'd1;
                    if (bit_cnt == 5'd24) begin
                        state <= st_norm;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // remainder, divisor and quotient shift register
    always_ff @(posedge clk) begin
        if (start) begin
            exp_int <= {2'b00, a_f.exp} - {2'b00, b_f.exp} + 10'(exp_bias);
            res_sign <= a_f.sign ^ b_f.sign;
        end
        if (start || state == st_run) begin
            rem <= rem_sub << 1;
            den <= den_in;
            quo <= start ? {24'd0, q_bit} : {quo[23:0], q_bit};
        end
    end

    // ============================
    // normalization and clamp
    // ============================
    always_comb begin
        shift = 9'sd0;
        found = 1'b0;
        quo_sh = quo;
        // leading one in bit 24 keeps the exponent and drops bit 0
        if (!quo[24]) begin
            for (int i = 24; i >= 0; i--) begin
                if (!found) begin
                    if (quo[i]) begin
                        found = 1'b1;
                    end else begin
                        shift = shift + 9'sd1;
                    end
                end
            end
            quo_sh = quo << shift;
        end
        norm_exp = exp_int - shift;
        // exponent clamped to 0..255
        if (norm_exp <= 10'sd0) begin
            res_exp = 8'd0;
        end else if (norm_exp > 10'sd255) begin
            res_exp = 8'hff;
        end else begin
            res_exp = norm_exp[7:0];
        end
        rsp.result = {res_sign, res_exp, quo_sh[23:1]};
        rsp.cmp = 1'b0;
    end

    assign done = (state == st_norm);

endmodule

// ==== logic/fpu_wb_regs.sv ====
`timescale 1ns/1ns
// Wishbone classic slave holding operands, opcode, result and status
// an opcode write starts the operation, later opcode writes stall until busy clears
module fpu_wb_regs #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [ADDR_W-1:0] wb_adr,
    input  fpu_pkg::fp_word_t wb_dat_w,
    output fpu_pkg::fp_word_t wb_dat_r,
    output logic              wb_ack,
    output fpu_pkg::fpu_req_t req,
    input  fpu_pkg::fpu_rsp_t alu_rsp,
    output logic              div_start,
    input  logic              div_done,
    input  fpu_pkg::fpu_rsp_t div_rsp
);
    import fpu_pkg::*;

    reg_addr_e addr;
    logic      access;
    logic      op_write;
    logic      ack_next;
    logic      busy;
    // opcode was captured on the previous edge
    logic      issued;
    fpu_rsp_t  res;

    assign addr = reg_addr_e'(wb_adr[4:2]);
    assign access = wb_cyc && wb_stb && !wb_ack;
    assign op_write = wb_we && (addr == reg_opcode);
    // back-pressure on the opcode register while an operation runs
    assign ack_next = access && !(op_write && busy);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            req <= '0;
            res <= '0;
            busy <= 1'b0;
            issued <= 1'b0;
            div_start <= 1'b0;
        end else begin
            wb_ack <= ack_next;
            issued <= 1'b0;
            div_start <= issued && (req.op == op_div);

            if (ack_next && wb_we) begin
                case (addr)
                    reg_op1: req.a <= wb_dat_w;
                    reg_op2: req.b <= wb_dat_w;
                    reg_opcode: begin
                        req.op <= fp_op_e'(wb_dat_w[3:0]);
                        busy <= 1'b1;
                        issued <= 1'b1;
                    end
                    default: ;
                endcase
            end

            // ALU ops finish one cycle after capture
            if (issued && req.op != op_div) begin
                res <= alu_rsp;
                busy <= 1'b0;
            end
            if (div_done) begin
                res <= div_rsp;
                busy <= 1'b0;
            end
        end
    end

    // read mux, unmapped words read as zero
    always_comb begin
        case (addr)
            reg_op1:    wb_dat_r = req.a;
            reg_op2:    wb_dat_r = req.b;
            reg_opcode: wb_dat_r = {28'd0, req.op};
            reg_result: wb_dat_r = res.result;
            reg_status: wb_dat_r = {30'd0, res.cmp, busy};
            default:    wb_dat_r = '0;
        endcase
    end

endmodule

// ==== logic/fpu_top.sv ====
`timescale 1ns/1ns
// top level of the floating-point coprocessor
// Wishbone register block feeding the combinational ALU and the divider
module fpu_top #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [ADDR_W-1:0] wb_adr,
    input  fpu_pkg::fp_word_t wb_dat_w,
    output fpu_pkg::fp_word_t wb_dat_r,
    output logic              wb_ack
);
    import fpu_pkg::*;

    fpu_req_t req;
    fpu_rsp_t alu_rsp;
    fpu_rsp_t div_rsp;
    logic     div_start;
    logic     div_done;

    fpu_wb_regs #(
        .ADDR_W(ADDR_W)
    ) u_regs (
        .clk(clk),
        .rst_n(rst_n),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .req(req),
        .alu_rsp(alu_rsp),
        .div_start(div_start),
        .div_done(div_done),
        .div_rsp(div_rsp)
    );

    floating_alu u_alu (
        .req(req),
        .rsp(alu_rsp)
    );

    fp_divider u_div (
        .clk(clk),
        .rst_n(rst_n),
        .start(div_start),
        .req(req),
        .done(div_done),
        .rsp(div_rsp)
    );

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ns
// clock and reset source for the FPU testbench
// 10 ns clock, active-low reset held for the first 16 rising edges
module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== testbench/fpu_props.sv ====
`timescale 1ns/1ns
// bus and busy properties of the FPU register block
// attached to fpu_wb_regs with bind from the testbench
module fpu_props (
    input logic       clk,
    input logic       rst_n,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_we,
    input logic [2:0] word,
    input logic       wb_ack,
    input logic       busy
);

    // ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles in a row");

    // no ack without a strobe in the cycle before
    ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a preceding strobe");

    // opcode writes stall while an operation runs
    no_ack_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && wb_stb && wb_we && word == 3'd2 && busy && !wb_ack) |=> !wb_ack)
        else $error("opcode write acknowledged while busy");

endmodule

bind fpu_wb_regs fpu_props u_props (
    .clk(clk),
    .rst_n(rst_n),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_we(wb_we),
    .word(wb_adr[4:2]),
    .wb_ack(wb_ack),
    .busy(busy)
);

// ==== testbench/fpu_tb.sv ====
`timescale 1ns/1ns
// testbench for the FPU coprocessor, replays the vectors of the data file
// each line is run as Wishbone writes, status polls and a result read
module fpu_tb;
    import fpu_pkg::*;

    localparam int addr_w = 8;

    logic              clk;
    logic              rst_n;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [addr_w-1:0] wb_adr;
    fp_word_t          wb_dat_w;
    fp_word_t          wb_dat_r;
    logic              wb_ack;

    string    names[$];
    int       ops[$];
    fp_word_t op1s[$];
    fp_word_t op2s[$];
    fp_word_t results[$];
    logic     cmps[$];

    integer seed = 32'h37ced00c;
    int     pass_count = 0;
    int     fail_count = 0;
    bit     test_failed;

    tb_clock u_clock (
        .clk(clk),
        .rst_n(rst_n)
    );

    fpu_top #(
        .ADDR_W(addr_w)
    ) dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack)
    );

    // ============================
    // bus master
    // ============================
    task automatic idle_gap();
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(posedge clk);
    endtask

    // cycles counts the falling edges until ack, 2 for an unstalled access
    task automatic bus_access(input reg_addr_e reg_idx, input logic we, input fp_word_t data,
                              output fp_word_t rdata, output int cycles);
        idle_gap();
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= addr_w'({reg_idx, 2'b00});
        wb_dat_w <= data;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_ack);
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic bus_write(input reg_addr_e reg_idx, input fp_word_t data, output int cycles);
        fp_word_t unused;
        bus_access(reg_idx, 1'b1, data, unused, cycles);
    endtask

    task automatic bus_read(input reg_addr_e reg_idx, output fp_word_t data);
        int cycles;
        bus_access(reg_idx, 1'b0, '0, data, cycles);
    endtask

    task automatic wait_not_busy(output fp_word_t status);
        do begin
            bus_read(reg_status, status);
        end while (status[0]);
    endtask

    // ============================
    // checks and reporting
    // ============================
    task automatic check_value(input string test, input string what,
                               input fp_word_t expected, input fp_word_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s expected %h actual %h", test, what, expected, actual);
            test_failed = 1'b1;
        end
    endtask

    task automatic report_test(input string test);
        if (test_failed) begin
            fail_count++;
            $display("FAIL %s", test);
        end else begin
            pass_count++;
            $display("PASS %s", test);
        end
    endtask

    // operands, opcode, optional busy check, poll, then compare result and cmp
    task automatic run_vector(input int i);
        fp_word_t status;
        fp_word_t result;
        int       cycles;
        test_failed = 1'b0;
        bus_write(reg_op1, op1s[i], cycles);
        bus_write(reg_op2, op2s[i], cycles);
        bus_write(reg_opcode, fp_word_t'(ops[i]), cycles);
        if (ops[i] == 4) begin
            bus_read(reg_status, status);
            check_value(names[i], "busy", 32'd1, {31'd0, status[0]});
        end
        wait_not_busy(status);
        bus_read(reg_result, result);
        check_value(names[i], "result", results[i], result);
        check_value(names[i], "cmp", {31'd0, cmps[i]}, {31'd0, status[1]});
        // abs touches only the sign bit
        if (ops[i] == 5) begin
            check_value(names[i], "abs", op1s[i] & 32'h7fff_ffff, result);
        end
        report_test(names[i]);
    endtask

    // divide on line i, add opcode from line i+1 written straight after it
    task automatic run_backpressure(input int i);
        fp_word_t status;
        fp_word_t result;
        fp_word_t div_result;
        int       cycles;
        test_failed = 1'b0;
        bus_write(reg_op1, op1s[i], cycles);
        bus_write(reg_op2, op2s[i], cycles);
        bus_write(reg_opcode, fp_word_t'(ops[i]), cycles);
        fork
            bus_write(reg_opcode, fp_word_t'(ops[i + 1]), cycles);
            begin
                // the divide result sits in the result register until the add lands
                do begin
                    @(negedge clk);
                end while (!wb_ack);
                div_result = dut0.u_regs.res.result;
            end
        join
        if (cycles <= 2) begin
            $display("ERROR %s: opcode write finished without waiting for the divide",
                     names[i + 1]);
            test_failed = 1'b1;
        end
        check_value(names[i], "result", results[i], div_result);
        report_test(names[i]);
        test_failed = 1'b0;
        wait_not_busy(status);
        bus_read(reg_result, result);
        check_value(names[i + 1], "result", results[i + 1], result);
        check_value(names[i + 1], "cmp", {31'd0, cmps[i + 1]}, {31'd0, status[1]});
        report_test(names[i + 1]);
    endtask

    task automatic load_vectors();
        int       fd;
        int       rc;
        string    line;
        string    name;
        int       op;
        fp_word_t a;
        fp_word_t b;
        fp_word_t res;
        int       cmp;
        fd = $fopen("testbench/fpu_testdata.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the test data file");
            return;
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
                rc = $sscanf(line, "%s %d %h %h %h %d", name, op, a, b, res, cmp);
                if (rc == 6) begin
                    names.push_back(name);
                    ops.push_back(op);
                    op1s.push_back(a);
                    op2s.push_back(b);
                    results.push_back(res);
                    cmps.push_back(cmp[0]);
                end
            end
        end
        $fclose(fd);
    endtask

    // ============================
    // main sequence and watchdog
    // ============================
    initial begin
        int i;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        load_vectors();
        if (names.size() == 0) begin
            fail_count++;
        end

        fork
            begin
                repeat (60 * names.size() + 32) @(posedge clk);
                $display("ERROR: the run timed out before all tests finished");
                $display("Some tests failed");
                $finish;
            end
        join_none

        @(posedge rst_n);
        repeat (2) @(posedge clk);
        i = 0;
        while (i < names.size()) begin
            if (names[i].substr(0, 5) == "bp_div" && i + 1 < names.size()) begin
                run_backpressure(i);
                i += 2;
            end else begin
                run_vector(i);
                i++;
            end
        end

        $display("passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== testbench/fpu_testdata.txt ====
# name op(decimal) op1(hex) op2(hex) result(hex) cmp
# a bp_div line followed by bp_add runs as the back-pressure pair on shared operands
add_carry 1 3f800000 3f800000 40000000 0
add_unequal 1 3f800000 40000000 40400000 0
add_carry_frac 1 3fc00000 3fc00000 40400000 0
sub_cancel 2 3fc00000 3fc00000 00000000 0
sub_unequal 2 40400000 3f800000 40000000 0
mul_int 3 40000000 40400000 40c00000 0
mul_carry 3 3fc00000 3fc00000 40100000 0
mul_neg 3 c0000000 40400000 c0c00000 0
abs_neg 5 c0400000 00000000 40400000 0
div_rshift 4 40c00000 40000000 40400000 0
div_half 4 3f800000 40000000 3f000000 0
div_lshift 4 40000000 40400000 3f2aaaaa 0
div_neg 4 bf800000 40800000 be800000 0
eq_same 6 3f800000 3f800000 00000000 1
neq_same 7 3f800000 3f800000 00000000 0
slt_mixed 8 bf800000 3f800000 00000000 1
slt_sameexp 8 3f800000 3fc00000 00000000 1
slt_greater 8 40000000 3f800000 00000000 0
slt_same 8 3f800000 3f800000 00000000 0
f2i_three 9 40400000 00000000 00000003 0
f2i_sat_pos 9 4f800000 00000000 7fffffff 0
f2i_sat_neg 9 cf800000 00000000 80000000 0
f2i_small 9 3f000000 00000000 00000000 0
i2f_neg 10 fffffffb 00000000 c0a00000 0
i2f_zero 10 00000000 00000000 00000000 0
bp_div 4 40c00000 40000000 40400000 0
bp_add 1 40c00000 40000000 41000000 0

// ==== all.f ====
logic/fpu_pkg.sv
logic/floating_alu.sv
logic/fp_divider.sv
logic/fpu_wb_regs.sv
logic/fpu_top.sv
testbench/tb_clock.sv
testbench/fpu_props.sv
testbench/fpu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = fpu_tb
FILELIST  = all.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Some tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
